//--- design/alu_branch.sv
// Execute stage: ALU, branch resolution, register write and retire record
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module alu_branch import core_pkg::*; (
    input  wire logic             clk_i,
    input  wire logic             rst_ni,
    input  wire issue_t           issue_i,
    output logic                  we_o,
    output logic [4:0]            waddr_o,
    output logic [`CORE_XLEN-1:0] wdata_o,
    output redirect_t             redirect_o,
    output retire_t               retire_o
);

    logic [`CORE_XLEN-1:0] result;
    logic                  taken;
    retire_t               retire_q;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (issue_i.op)
            ALU_ADD:      result = issue_i.opa + issue_i.opb;
            ALU_SUB:      result = issue_i.opa - issue_i.opb;
            ALU_AND:      result = issue_i.opa & issue_i.opb;
            ALU_OR:       result = issue_i.opa | issue_i.opb;
            ALU_XOR:      result = issue_i.opa ^ issue_i.opb;
            ALU_SLT:      result = {{(`CORE_XLEN-1){1'b0}},
                                    $signed(issue_i.opa) < $signed(issue_i.opb)};
            ALU_PASS_IMM: result = issue_i.imm;
            ALU_BEQ:      taken  = (issue_i.opa == issue_i.opb);
            ALU_BNE:      taken  = (issue_i.opa != issue_i.opb);
            ALU_BLT:      taken  = $signed(issue_i.opa) < $signed(issue_i.opb);
            default:      result = '0;
        endcase
    end

    assign we_o    = issue_i.valid & issue_i.we;
    assign waddr_o = issue_i.rd;
    assign wdata_o = result;

    // Not-taken prediction, only a taken branch redirects
    assign redirect_o.valid  = issue_i.valid & taken;
    assign redirect_o.target = issue_i.pc + issue_i.imm;

    // ------------------------------------------------------------
    // Retire record, one cycle after execute
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            retire_q <= '0;
        end else begin
            retire_q.valid <= issue_i.valid;
            retire_q.pc    <= issue_i.pc;
            retire_q.rd    <= issue_i.rd;
            retire_q.we    <= we_o;
            retire_q.wdata <= result;
        end
    end

    assign retire_o = retire_q;

endmodule

`default_nettype wire

//--- design/core_pkg.sv
// Shared core types: instruction views, memory bus records and pipeline records
`default_nettype none
`include "core_config.svh"

package core_pkg;

    // ------------------------------------------------------------
    // Instruction encoding
    // ------------------------------------------------------------
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_PASS_IMM, ALU_BEQ, ALU_BNE, ALU_BLT
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_rtype_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_itype_t;

    // Same word, register view or immediate view
    typedef union packed {
        rv_rtype_t r;
        rv_itype_t i;
    } rv_instr_u;

    // ------------------------------------------------------------
    // Instruction memory bus
    // ------------------------------------------------------------
    typedef struct packed {
        logic                  req;
        logic [`CORE_XLEN-1:0] addr;
    } instr_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } instr_rsp_t;

    // ------------------------------------------------------------
    // Pipeline records
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        rv_instr_u             instr;
    } fetch_entry_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               op;
        logic [`CORE_XLEN-1:0] opa;
        logic [`CORE_XLEN-1:0] opb;
        logic [`CORE_XLEN-1:0] imm;
        logic [4:0]            rd;
        logic                  we;
        logic [`CORE_XLEN-1:0] pc;
    } issue_t;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        logic [4:0]            rd;
        logic                  we;
        logic [`CORE_XLEN-1:0] wdata;
    } retire_t;

endpackage

`default_nettype wire

//--- design/core_top.sv
// Core top level, wires fetch, fetch queue, decode, register file and execute
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module core_top import core_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  fetch_enable_i,
    input  wire logic [`CORE_XLEN-1:0] boot_addr_i,
    output instr_req_t                 instr_req_o,
    input  wire instr_rsp_t            instr_rsp_i,
    output retire_t                    retire_o
);

    // ------------------------------------------------------------
    // Fetch side
    // ------------------------------------------------------------
    logic                  grant;
    logic                  flush;
    logic                  credit;
    logic                  drop;
    logic                  push;
    fetch_entry_t          push_entry;
    logic [1:0]            queue_count;

    // ------------------------------------------------------------
    // Decode and execute side
    // ------------------------------------------------------------
    logic                  head_valid;
    fetch_entry_t          head;
    logic                  pop;
    logic [4:0]            raddr_a;
    logic [4:0]            raddr_b;
    logic [`CORE_XLEN-1:0] rdata_a;
    logic [`CORE_XLEN-1:0] rdata_b;
    issue_t                issue;
    logic                  we;
    logic [4:0]            waddr;
    logic [`CORE_XLEN-1:0] wdata;
    redirect_t             redirect;

    fetch_fsm u_fetch_fsm (
        .clk_i, .rst_ni, .fetch_enable_i, .boot_addr_i, .instr_req_o, .instr_rsp_i,
        .redirect_i   (redirect),
        .credit_i     (credit),
        .drop_i       (drop),
        .grant_o      (grant),
        .flush_o      (flush),
        .push_o       (push),
        .push_entry_o (push_entry)
    );

    fetch_counter u_fetch_counter (
        .clk_i, .rst_ni,
        .grant_i       (grant),
        .rvalid_i      (instr_rsp_i.rvalid),
        .flush_i       (flush),
        .queue_count_i (queue_count),
        .credit_o      (credit),
        .drop_o        (drop)
    );

    fetch_queue u_fetch_queue (
        .clk_i, .rst_ni,
        .push_i       (push),
        .push_entry_i (push_entry),
        .pop_i        (pop),
        .clear_i      (redirect.valid),
        .head_valid_o (head_valid),
        .head_o       (head),
        .count_o      (queue_count)
    );

    decode_issue u_decode_issue (
        .clk_i, .rst_ni,
        .head_valid_i (head_valid),
        .head_i       (head),
        .pop_o        (pop),
        .kill_i       (redirect.valid),
        .raddr_a_o    (raddr_a),
        .raddr_b_o    (raddr_b),
        .rdata_a_i    (rdata_a),
        .rdata_b_i    (rdata_b),
        .issue_o      (issue)
    );

    reg_file u_reg_file (
        .clk_i, .rst_ni,
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .we_i      (we),
        .waddr_i   (waddr),
        .wdata_i   (wdata)
    );

    alu_branch u_alu_branch (
        .clk_i, .rst_ni, .retire_o,
        .issue_i    (issue),
        .we_o       (we),
        .waddr_o    (waddr),
        .wdata_o    (wdata),
        .redirect_o (redirect)
    );

endmodule

`default_nettype wire

//--- design/decode_issue.sv
// Decode of the fetch queue head, operand read and issue register feeding execute
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module decode_issue import core_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  head_valid_i,
    input  wire fetch_entry_t          head_i,
    output logic                       pop_o,
    input  wire logic                  kill_i,
    output logic [4:0]                 raddr_a_o,
    output logic [4:0]                 raddr_b_o,
    input  wire logic [`CORE_XLEN-1:0] rdata_a_i,
    input  wire logic [`CORE_XLEN-1:0] rdata_b_i,
    output issue_t                     issue_o
);

    rv_instr_u             instr;
    alu_op_e               op;
    logic [`CORE_XLEN-1:0] imm;
    logic                  we;
    logic                  use_imm;
    issue_t                issue_q;

    assign instr     = head_i.instr;
    assign raddr_a_o = instr.r.rs1;
    assign raddr_b_o = instr.r.rs2;

    // Execute never stalls, so the head is taken whenever present
    assign pop_o = head_valid_i;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    always_comb begin
        op      = ALU_ADD;
        we      = 1'b0;
        use_imm = 1'b0;
        imm     = {{(`CORE_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
        case (instr.r.opcode)
            OPC_OP, OPC_OP_IMM: begin
                we      = 1'b1;
                use_imm = (instr.r.opcode == OPC_OP_IMM);
                case (instr.r.funct3)
                    3'b000: op = (!use_imm && instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b010: op = ALU_SLT;
                    3'b100: op = ALU_XOR;
                    3'b110: op = ALU_OR;
                    3'b111: op = ALU_AND;
                    default: we = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                // B-type offset is scattered over funct7 and rd
                imm = {{(`CORE_XLEN-12){instr.r.funct7[6]}}, instr.r.rd[0],
                       instr.r.funct7[5:0], instr.r.rd[4:1], 1'b0};
                case (instr.r.funct3)
                    3'b000: op = ALU_BEQ;
                    3'b001: op = ALU_BNE;
                    3'b100: op = ALU_BLT;
                    default: op = ALU_ADD;
                endcase
            end
            OPC_LUI: begin
                op  = ALU_PASS_IMM;
                we  = 1'b1;
                imm = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'b0};
            end
            default: begin
                // Unsupported, retires as a no-op
                we = 1'b0;
            end
        endcase
        we = we & (instr.r.rd != 5'd0);
    end

    // ------------------------------------------------------------
    // Issue register
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            issue_q <= '0;
        end else begin
            issue_q.valid <= head_valid_i & ~kill_i;
            if (head_valid_i) begin
                issue_q.op  <= op;
                issue_q.opa <= rdata_a_i;
                issue_q.opb <= use_imm ? imm : rdata_b_i;
                issue_q.imm <= imm;
                issue_q.rd  <= instr.r.rd;
                issue_q.we  <= we;
                issue_q.pc  <= head_i.pc;
            end
        end
    end

    assign issue_o = issue_q;

endmodule

`default_nettype wire

//--- design/fetch_counter.sv
// Outstanding and discard counters for instruction fetch, grants request credit
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module fetch_counter (
    input  wire logic       clk_i,
    input  wire logic       rst_ni,
    input  wire logic       grant_i,
    input  wire logic       rvalid_i,
    input  wire logic       flush_i,
    input  wire logic [1:0] queue_count_i,
    output logic            credit_o,
    output logic            drop_o
);

    localparam int CW = $clog2(`FETCH_MAX_OUTSTANDING + 1);

    logic [CW-1:0] outstanding_q;
    logic [CW-1:0] outstanding_d;
    logic [CW-1:0] discard_q;

    assign outstanding_d = outstanding_q + CW'(grant_i) - CW'(rvalid_i);

    // Count this cycle's grant so back-to-back requests cannot overrun the queue
    assign credit_o = (int'(outstanding_q) + int'(grant_i) + int'(queue_count_i)
                       < `FETCH_QUEUE_DEPTH)
                    && (int'(outstanding_q) + int'(grant_i) < `FETCH_MAX_OUTSTANDING);

    assign drop_o = rvalid_i & (discard_q != '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            outstanding_q <= '0;
            discard_q     <= '0;
        end else begin
            outstanding_q <= outstanding_d;
            // On flush every unanswered request becomes wrong path
            if (flush_i) discard_q <= outstanding_d;
            else if (drop_o) discard_q <= discard_q - 1'b1;
        end
    end

    a_no_orphan_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i |-> outstanding_q != '0);
    a_max_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
        int'(outstanding_q) <= `FETCH_MAX_OUTSTANDING);

endmodule

`default_nettype wire

//--- design/fetch_fsm.sv
// Fetch stage: next PC, instruction memory request FSM and response pairing, under core_top
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module fetch_fsm import core_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  fetch_enable_i,
    input  wire logic [`CORE_XLEN-1:0] boot_addr_i,
    output instr_req_t                 instr_req_o,
    input  wire instr_rsp_t            instr_rsp_i,
    input  wire redirect_t             redirect_i,
    input  wire logic                  credit_i,
    input  wire logic                  drop_i,
    output logic                       grant_o,
    output logic                       flush_o,
    output logic                       push_o,
    output fetch_entry_t               push_entry_o
);

    localparam int PW = $clog2(`FETCH_MAX_OUTSTANDING);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_e;

    state_e                state_q;
    logic                  en_q;
    logic                  stale_q;
    logic [`CORE_XLEN-1:0] pc_q;
    logic [`CORE_XLEN-1:0] addr_q;
    logic [`CORE_XLEN-1:0] fetch_pc;
    logic                  free;
    logic                  launch;
    // PCs of granted requests, in request order
    logic [`CORE_XLEN-1:0] pend_pc_q [`FETCH_MAX_OUTSTANDING];
    logic [PW-1:0]         wr_ptr_q;
    logic [PW-1:0]         rd_ptr_q;

    assign instr_req_o.req  = (state_q == ST_REQ);
    assign instr_req_o.addr = addr_q;
    assign grant_o          = instr_req_o.req & instr_rsp_i.gnt;

    // A request left over from before a redirect is wrong path once granted
    assign flush_o = redirect_i.valid | (stale_q & grant_o);

    assign fetch_pc = redirect_i.valid ? redirect_i.target : pc_q;
    assign free     = (state_q != ST_REQ) | instr_rsp_i.gnt;
    assign launch   = free & en_q & credit_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= ST_IDLE;
            en_q     <= 1'b0;
            stale_q  <= 1'b0;
            pc_q     <= boot_addr_i;
            addr_q   <= boot_addr_i;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            en_q    <= fetch_enable_i;
            stale_q <= (state_q == ST_REQ) & ~instr_rsp_i.gnt & (redirect_i.valid | stale_q);
            pc_q    <= launch ? fetch_pc + `CORE_XLEN'd4 : fetch_pc;
            if (launch) begin
                state_q <= ST_REQ;
                addr_q  <= fetch_pc;
            end else if (free) begin
                state_q <= en_q ? ST_WAIT : ST_IDLE;
            end
            if (grant_o) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (instr_rsp_i.rvalid) rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant_o) pend_pc_q[wr_ptr_q] <= addr_q;
    end

    // Responses landing in a redirect cycle are wrong path too
    assign push_o             = instr_rsp_i.rvalid & ~drop_i & ~redirect_i.valid;
    assign push_entry_o.pc    = pend_pc_q[rd_ptr_q];
    assign push_entry_o.instr = instr_rsp_i.rdata;

    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_req_o.req && !instr_rsp_i.gnt |=> instr_req_o.req && $stable(instr_req_o.addr));

endmodule

`default_nettype wire

//--- design/fetch_queue.sv
// Fetch queue between fetch and decode, holds instruction words with their PCs
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module fetch_queue import core_pkg::*; (
    input  wire logic         clk_i,
    input  wire logic         rst_ni,
    input  wire logic         push_i,
    input  wire fetch_entry_t push_entry_i,
    input  wire logic         pop_i,
    input  wire logic         clear_i,
    output logic              head_valid_o,
    output fetch_entry_t      head_o,
    output logic [1:0]        count_o
);

    localparam int PW = $clog2(`FETCH_QUEUE_DEPTH);

    fetch_entry_t  mem_q [`FETCH_QUEUE_DEPTH];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [1:0]    count_q;
    logic          do_pop;

    assign head_valid_o = (count_q != 2'd0);
    assign head_o       = mem_q[rd_ptr_q];
    assign count_o      = count_q;
    assign do_pop       = pop_i & head_valid_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= 2'd0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= 2'd0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + 2'(push_i) - 2'(do_pop);
        end
    end

    // Storage only, pointers qualify it
    always_ff @(posedge clk_i) begin
        if (push_i) mem_q[wr_ptr_q] <= push_entry_i;
    end

    // Fetch credit must leave room for every response
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i && int'(count_q) == `FETCH_QUEUE_DEPTH |-> pop_i);

endmodule

`default_nettype wire

//--- design/reg_file.sv
// Integer register file, two read ports and one write port with write-through bypass
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module reg_file (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic [4:0]            raddr_a_i,
    input  wire logic [4:0]            raddr_b_i,
    output logic [`CORE_XLEN-1:0]      rdata_a_o,
    output logic [`CORE_XLEN-1:0]      rdata_b_o,
    input  wire logic                  we_i,
    input  wire logic [4:0]            waddr_i,
    input  wire logic [`CORE_XLEN-1:0] wdata_i
);

    logic [`CORE_XLEN-1:0] regs_q [`CORE_NR_REGS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `CORE_NR_REGS; i++) regs_q[i] <= '0;
        end else if (we_i && waddr_i != 5'd0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero, a same-cycle write is forwarded
    assign rdata_a_o = (raddr_a_i == 5'd0) ? '0 :
                       (we_i && waddr_i == raddr_a_i) ? wdata_i : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 5'd0) ? '0 :
                       (we_i && waddr_i == raddr_b_i) ? wdata_i : regs_q[raddr_b_i];

endmodule

`default_nettype wire

//--- include/core_config.svh
// Core build constants, included by the core package and by modules that size by them
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data and address width
`define CORE_XLEN 32

// Architectural integer registers, x0 included
`define CORE_NR_REGS 32

// ------------------------------------------------------------
// Fetch sizing
// ------------------------------------------------------------

// Entries in the fetch queue
`define FETCH_QUEUE_DEPTH 2

// Granted instruction requests that may await a response
`define FETCH_MAX_OUTSTANDING 2

`endif

//--- tb.f
+incdir+include
design/core_pkg.sv
design/fetch_fsm.sv
design/fetch_counter.sv
design/fetch_queue.sv
design/decode_issue.sv
design/reg_file.sv
design/alu_branch.sv
design/core_top.sv
verification/tb_core.sv

//--- verification/core_testdata.txt
// Tag 1 lines hold addr and instr, tag 2 lines hold pc rd we value of one retire, tag 0 ends
// Expected retires are in program order and rd and value count only when we is 1
1 00000080 00500093
1 00000084 ffd00113
1 00000088 002081b3
1 0000008c 40118233
1 00000090 001272b3
1 00000094 0022e333
1 00000098 001343b3
1 0000009c 00112433
1 000000a0 fff0a493
1 000000a4 12345537
1 000000a8 67854593
1 000000ac 00308463
1 000000b0 00309663
1 000000b4 00100613
1 000000b8 00200613
1 000000bc 0000008b
1 000000c0 00008693
1 000000c4 00114463
1 000000c8 00700693
1 000000cc 0020c463
1 000000d0 00d68733
1 000000d4 00000063
// Arithmetic chain with back-to-back dependences
2 00000080 01 1 00000005
2 00000084 02 1 fffffffd
2 00000088 03 1 00000002
2 0000008c 04 1 fffffffd
2 00000090 05 1 00000005
2 00000094 06 1 fffffffd
2 00000098 07 1 fffffff8
2 0000009c 08 1 00000001
2 000000a0 09 1 00000000
2 000000a4 0a 1 12345000
2 000000a8 0b 1 12345678
// Branches and the unknown opcode
2 000000ac 00 0 00000000
2 000000b0 00 0 00000000
2 000000bc 00 0 00000000
2 000000c0 0d 1 00000005
2 000000c4 00 0 00000000
2 000000cc 00 0 00000000
2 000000d0 0e 1 0000000a
2 000000d4 00 0 00000000
0

//--- verification/tb_core.sv
// Testbench for the core top level, runs the program and retire list from the test data file
`timescale 1ns/1ps
`default_nettype none

module tb_core import core_pkg::*; ();

    localparam logic [31:0] BOOT       = 32'h0000_0080;
    localparam logic [31:0] LFSR_SEED  = 32'h8361;
    localparam int          MEM_WORDS  = 64;
    localparam int          TD_WORDS   = 256;
    localparam int          MAX_EXP    = 64;

    logic        clk;
    logic        rst_n;
    logic        fetch_enable;
    logic [31:0] boot_addr;
    instr_req_t  instr_req;
    instr_rsp_t  instr_rsp;
    retire_t     retire;

    logic [31:0] tdata [TD_WORDS];
    logic [31:0] imem [MEM_WORDS];
    logic [31:0] exp_pc [MAX_EXP];
    logic [4:0]  exp_rd [MAX_EXP];
    logic        exp_we [MAX_EXP];
    logic [31:0] exp_val [MAX_EXP];
    int          n_exp = 0;
    int          ridx = 0;
    bit          done = 1'b0;
    logic [31:0] lfsr;

    // Responses owed by the memory model, oldest first
    logic [31:0] pend_addr [$];
    int          pend_ready [$];

    // Monitor state, sampled at the falling edge
    bit          en_seen = 1'b0;
    bit          first_req_done = 1'b0;
    bit          held_req = 1'b0;
    logic [31:0] held_addr = '0;

    core_top uut (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .fetch_enable_i (fetch_enable),
        .boot_addr_i    (boot_addr),
        .instr_req_o    (instr_req),
        .instr_rsp_i    (instr_rsp),
        .retire_o       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_two_bits(output int v);
        lfsr = lfsr_step(lfsr);
        v = lfsr[0];
        lfsr = lfsr_step(lfsr);
        v = 2 * v + lfsr[0];
    endtask

    // Unknown opcode with the address folded into the upper bits
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[31:7] ^ addr[24:0], 7'h7f};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr >= BOOT && addr < BOOT + 4 * MEM_WORDS) return imem[(addr - BOOT) >> 2];
        return fill_word(addr);
    endfunction

    task automatic load_testdata();
        int pos;
        int idx;
        for (int a = 0; a < MEM_WORDS; a++) imem[a] = fill_word(BOOT + 4 * a);
        $readmemh("verification/core_testdata.txt", tdata);
        pos = 0;
        while (tdata[pos] !== 32'h0) begin
            case (tdata[pos])
                32'h1: begin
                    idx = int'((tdata[pos + 1] - BOOT) >> 2);
                    assert (tdata[pos + 1] >= BOOT && idx < MEM_WORDS) else begin
                        $display("Program address %h lies outside the memory", tdata[pos + 1]);
                        abort_run();
                    end
                    imem[idx] = tdata[pos + 2];
                    pos += 3;
                end
                32'h2: begin
                    assert (n_exp < MAX_EXP) else begin
                        $display("Too many expected retire records in the test data");
                        abort_run();
                    end
                    exp_pc[n_exp]  = tdata[pos + 1];
                    exp_rd[n_exp]  = tdata[pos + 2][4:0];
                    exp_we[n_exp]  = tdata[pos + 3][0];
                    exp_val[n_exp] = tdata[pos + 4];
                    n_exp++;
                    pos += 5;
                end
                default: begin
                    $display("Test data word %0d is not a known record tag", pos);
                    abort_run();
                end
            endcase
        end
        assert (n_exp > 0) else begin
            $display("Test data holds no expected retire records");
            abort_run();
        end
    endtask

    task automatic check_retire();
        assert (ridx < n_exp) else begin
            $display("Retire at pc %h after the expected sequence ended", retire.pc);
            abort_run();
        end
        assert (retire.pc == exp_pc[ridx]) else begin
            $display("Fail retire_o.pc record %0d: got %h expected %h",
                     ridx, retire.pc, exp_pc[ridx]);
            abort_run();
        end
        assert (retire.we == exp_we[ridx]) else begin
            $display("Fail retire_o.we record %0d: got %h expected %h",
                     ridx, retire.we, exp_we[ridx]);
            abort_run();
        end
        // Destination and value only mean something for a register write
        if (exp_we[ridx]) begin
            assert (retire.rd == exp_rd[ridx]) else begin
                $display("Fail retire_o.rd record %0d: got %h expected %h",
                         ridx, retire.rd, exp_rd[ridx]);
                abort_run();
            end
            assert (retire.wdata == exp_val[ridx]) else begin
                $display("Fail retire_o.wdata record %0d: got %h expected %h",
                         ridx, retire.wdata, exp_val[ridx]);
                abort_run();
            end
        end
        ridx++;
        if (ridx == n_exp) done = 1'b1;
    endtask

    // ------------------------------------------------------------
    // Instruction memory with random grant and response delays
    // ------------------------------------------------------------
    initial begin : memory_model
        int          d;
        int          gnt_wait;
        bit          gnt_armed;
        int          cyc;
        logic [31:0] gnt_addr;
        instr_rsp = '0;
        lfsr      = LFSR_SEED;
        gnt_wait  = 0;
        gnt_armed = 1'b0;
        cyc       = 0;
        gnt_addr  = '0;
        forever begin
            @(posedge clk);
            #1;
            cyc++;
            // The grant driven last cycle completed at this edge
            if (instr_rsp.gnt) begin
                draw_two_bits(d);
                pend_addr.push_back(gnt_addr);
                pend_ready.push_back(cyc + ((d == 0) ? 1 : d) - 1);
            end
            instr_rsp.gnt = 1'b0;
            if (instr_req.req) begin
                if (!gnt_armed) begin
                    draw_two_bits(gnt_wait);
                    gnt_armed = 1'b1;
                end
                if (gnt_wait == 0) begin
                    instr_rsp.gnt = 1'b1;
                    gnt_armed     = 1'b0;
                    gnt_addr      = instr_req.addr;
                end else begin
                    gnt_wait--;
                end
            end
            instr_rsp.rvalid = 1'b0;
            instr_rsp.rdata  = '0;
            if (pend_ready.size() != 0 && pend_ready[0] <= cyc) begin
                instr_rsp.rvalid = 1'b1;
                instr_rsp.rdata  = fetch_word(pend_addr.pop_front());
                void'(pend_ready.pop_front());
            end
        end
    end

    // ------------------------------------------------------------
    // Bus and retire monitor
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst_n || !en_seen) begin
            assert (!instr_req.req) else begin
                $display("Request raised during reset or before fetch enable");
                abort_run();
            end
            assert (!retire.valid) else begin
                $display("Retire valid raised during reset or before fetch enable");
                abort_run();
            end
        end
        if (instr_req.req && !first_req_done) begin
            assert (instr_req.addr == BOOT) else begin
                $display("Fail instr_req_o.addr: got %h expected %h", instr_req.addr, BOOT);
                abort_run();
            end
            first_req_done = 1'b1;
        end
        if (held_req) begin
            assert (instr_req.req) else begin
                $display("Request valid dropped before its grant");
                abort_run();
            end
            assert (instr_req.addr == held_addr) else begin
                $display("Fail instr_req_o.addr: got %h expected %h", instr_req.addr, held_addr);
                abort_run();
            end
        end
        held_req  = instr_req.req && !instr_rsp.gnt;
        held_addr = instr_req.addr;
        if (retire.valid) check_retire();
        en_seen = fetch_enable;
    end

    initial begin : main
        int limit;
        int cycles;
        rst_n        = 1'b0;
        fetch_enable = 1'b0;
        boot_addr    = BOOT;
        load_testdata();
        limit = 40 * n_exp + 100;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        // A few idle cycles with fetch held off
        repeat (4) @(posedge clk);
        #1 fetch_enable = 1'b1;
        cycles = 0;
        while (!done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (done) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("Timeout after %0d cycles with %0d of %0d retires seen",
                     cycles, ridx, n_exp);
            abort_run();
        end
    end

endmodule

`default_nettype wire
